//--- sim.f
design/mcr_input_pkg.sv
design/mouse_tracker.sv
design/spinner.sv
design/input_port_mux.sv
design/mcr_input_top.sv
dv/spinner_checker.sv
dv/input_port_monitor.sv
dv/tb_mcr_input.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_mcr_input
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log for the pass message"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/mcr_input_tests.txt
# name game rst p1dir p2dir p1fire p2fire coin start tilt svc opt rot fast
#   nstrobe dx dy btn nvsync port0 port1 port2 port3 port4 (all hex except name)
reset_idle 0 1 0 0 0 0 0 0 0 0 0 0 0 0 000 000 0 0 ff ff ff ff ff
shollow_btns 0 0 1 2 1 2 1 1 0 0 0 0 0 0 000 000 0 0 fa a5 ff fd ff
twotiger_btns 2 0 0 0 3 2 2 4 1 1 0 0 0 0 000 000 0 0 4d ff f4 ff ff
domino_opts 5 0 8 4 1 1 0 2 0 0 3 0 0 0 000 000 0 0 e7 fb e7 bc ff
tron_spin_slow 1 0 0 1 0 0 0 0 0 0 1 0 0 0 000 000 0 4 ff fb ff f9 fb
tron_spin_fast 1 0 4 2 0 0 0 0 0 0 0 0 1 0 000 000 0 2 ff 85 77 fd 85
wacko_plain 3 0 0 0 0 0 0 0 0 0 0 0 0 3 028 1f0 0 0 ff 0f fa bf ff
wacko_rotate 3 0 8 1 0 0 0 0 0 0 0 1 0 2 040 020 0 0 ff f8 10 bf e7
kroozr_sat 4 0 0 0 0 0 0 0 0 0 0 0 0 4 0c8 0c8 2 0 ff 47 dc bf 24
kroozr_rot_left 4 0 0 0 0 0 0 0 0 0 0 1 0 3 100 064 1 0 ef c7 0b bf c0
kroozr_spin 4 0 2 0 0 0 0 0 0 0 0 0 1 0 000 000 0 2 ff 80 00 bf 00

//--- dv/tb_mcr_input.sv
// mcr input testbench
// reads the test table, drives buttons, mouse strobes and vsync
// pulses into the DUT and prints the closing summary
`timescale 1ns/100ps
`default_nettype none

module tb_mcr_input;
	import mcr_input_pkg::*;

	localparam int MAX_TESTS = 32;
	localparam string TEST_FILE = "dv/mcr_input_tests.txt";

	logic clk_sys = 1'b0;
	logic hard_reset;
	game_t game_sel;
	dir_t p1_dir, p2_dir;
	fire_t p1_fire, p2_fire;
	logic [1:0] coin, option, mouse_btn;
	logic [2:0] start;
	logic tilt, service, rotate, spin_fast, vsync, mouse_strobe;
	mouse_delta_t mouse_dx, mouse_dy;
	port_byte_t port0, port1, port2, port3, port4;
	port_byte_t exp0, exp1, exp2, exp3, exp4;
	logic check_req;
	logic [191:0] cur_name;
	int errors;
	int checks;

	// ====================
	// test table
	// ====================
	// fld columns 0 game, 1 rst, 2-12 buttons and options, 13 nstrobe
	// 14 dx, 15 dy, 16 btn, 17 nvsync, 18-22 expected ports
	logic [191:0] t_name [MAX_TESTS];
	logic [8:0]   fld [MAX_TESTS][23];
	int num_tests = 0;
	int load_errors = 0;
	logic loaded = 1'b0;

	// 4 ns period
	always #2 clk_sys = ~clk_sys;

	mcr_input_top u_mcr_input_top (
		.clk_sys(clk_sys), .hard_reset(hard_reset), .game_sel_i(game_sel),
		.p1_dir_i(p1_dir), .p2_dir_i(p2_dir), .p1_fire_i(p1_fire), .p2_fire_i(p2_fire),
		.coin_i(coin), .start_i(start), .tilt_i(tilt), .service_i(service),
		.option_i(option), .rotate_i(rotate), .spin_fast_i(spin_fast), .vsync_i(vsync),
		.mouse_dx_i(mouse_dx), .mouse_dy_i(mouse_dy), .mouse_btn_i(mouse_btn),
		.mouse_strobe_i(mouse_strobe), .port0_o(port0), .port1_o(port1),
		.port2_o(port2), .port3_o(port3), .port4_o(port4)
	);

	input_port_monitor u_monitor (
		.clk_sys(clk_sys), .check_i(check_req), .test_name_i(cur_name),
		.exp0_i(exp0), .exp1_i(exp1), .exp2_i(exp2), .exp3_i(exp3), .exp4_i(exp4),
		.port0_i(port0), .port1_i(port1), .port2_i(port2), .port3_i(port3),
		.port4_i(port4), .error_count_o(errors), .check_count_o(checks)
	);

	task automatic load_tests();
		int fd;
		int got;
		string line;
		fd = $fopen(TEST_FILE, "r");
		if (fd == 0) begin
			$display("could not open the test table %s", TEST_FILE);
			load_errors++;
			return;
		end
		while (!$feof(fd) && num_tests < MAX_TESTS) begin
			got = $fgets(line, fd);
			// skip blanks and column notes
			if (got == 0 || line.len() < 2 || line.getc(0) == "#")
				continue;
			got = $sscanf(line,
				"%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				t_name[num_tests], fld[num_tests][0], fld[num_tests][1], fld[num_tests][2],
				fld[num_tests][3], fld[num_tests][4], fld[num_tests][5], fld[num_tests][6],
				fld[num_tests][7], fld[num_tests][8], fld[num_tests][9], fld[num_tests][10],
				fld[num_tests][11], fld[num_tests][12], fld[num_tests][13],
				fld[num_tests][14], fld[num_tests][15], fld[num_tests][16],
				fld[num_tests][17], fld[num_tests][18], fld[num_tests][19],
				fld[num_tests][20], fld[num_tests][21], fld[num_tests][22]);
			if (got != 24) begin
				$display("malformed line in the test table: %s", line);
				load_errors++;
			end else begin
				num_tests++;
			end
		end
		$fclose(fd);
	endtask

	// one cycle high then three low
	task automatic pulse_strobe(input int t);
		@(posedge clk_sys);
		mouse_strobe <= 1'b1;
		mouse_dx <= fld[t][14];
		mouse_dy <= fld[t][15];
		mouse_btn <= fld[t][16][1:0];
		@(posedge clk_sys);
		mouse_strobe <= 1'b0;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic pulse_vsync();
		@(posedge clk_sys);
		vsync <= 1'b1;
		@(posedge clk_sys);
		vsync <= 1'b0;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic run_test(input int t);
		@(posedge clk_sys);
		hard_reset <= 1'b1;
		game_sel <= game_t'(fld[t][0][2:0]);
		p1_dir <= fld[t][2][3:0];
		p2_dir <= fld[t][3][3:0];
		p1_fire <= fld[t][4][2:0];
		p2_fire <= fld[t][5][2:0];
		coin <= fld[t][6][1:0];
		start <= fld[t][7][2:0];
		tilt <= fld[t][8][0];
		service <= fld[t][9][0];
		option <= fld[t][10][1:0];
		rotate <= fld[t][11][0];
		spin_fast <= fld[t][12][0];
		repeat (5) @(posedge clk_sys);
		// rst flag keeps reset on for the compare
		if (!fld[t][1][0])
			hard_reset <= 1'b0;
		repeat (fld[t][13]) pulse_strobe(t);
		repeat (fld[t][17]) pulse_vsync();
		repeat (4) @(posedge clk_sys);
		cur_name <= t_name[t];
		exp0 <= fld[t][18][7:0];
		exp1 <= fld[t][19][7:0];
		exp2 <= fld[t][20][7:0];
		exp3 <= fld[t][21][7:0];
		exp4 <= fld[t][22][7:0];
		check_req <= 1'b1;
		@(posedge clk_sys);
		check_req <= 1'b0;
	endtask

	// ====================
	// main sequence
	// ====================
	initial begin
		int assert_fails;
		int total;
		hard_reset = 1'b1;
		game_sel = SHOLLOW;
		p1_dir = '0;
		p2_dir = '0;
		p1_fire = '0;
		p2_fire = '0;
		coin = '0;
		start = '0;
		tilt = 1'b0;
		service = 1'b0;
		option = '0;
		rotate = 1'b0;
		spin_fast = 1'b0;
		vsync = 1'b0;
		mouse_dx = '0;
		mouse_dy = '0;
		mouse_btn = '0;
		mouse_strobe = 1'b0;
		check_req = 1'b0;
		cur_name = '0;
		{exp0, exp1, exp2, exp3, exp4} = '1;
		load_tests();
		if (num_tests == 0) begin
			$display("no tests were read from the test table");
			load_errors++;
		end
		loaded = 1'b1;
		for (int t = 0; t < num_tests; t++)
			run_test(t);
		repeat (2) @(posedge clk_sys);
		if (checks != num_tests) begin
			$display("only %0d of %0d tests were compared", checks, num_tests);
			load_errors++;
		end
		assert_fails = u_mcr_input_top.u_spin1.u_spinner_checker.fail_count +
			u_mcr_input_top.u_spin2.u_spinner_checker.fail_count;
		total = errors + load_errors + assert_fails;
		$display("%0d tests, %0d errors, %0d other failures, %0d assertion failures",
			num_tests, errors, load_errors, assert_fails);
		if (total == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// watchdog budget scales with the table
	initial begin
		wait (loaded);
		repeat (num_tests * 40 + 100) @(posedge clk_sys);
		$display("timeout: tests did not finish within %0d cycles", num_tests * 40 + 100);
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/input_port_monitor.sv
// input port monitor
// compares the five CPU ports with the expected bytes on request
// and keeps the error and check counts
`timescale 1ns/100ps
`default_nettype none

module input_port_monitor (
	input  wire                             clk_sys,
	input  wire                             check_i,
	input  wire [191:0]                     test_name_i,
	input  wire mcr_input_pkg::port_byte_t  exp0_i,
	input  wire mcr_input_pkg::port_byte_t  exp1_i,
	input  wire mcr_input_pkg::port_byte_t  exp2_i,
	input  wire mcr_input_pkg::port_byte_t  exp3_i,
	input  wire mcr_input_pkg::port_byte_t  exp4_i,
	input  wire mcr_input_pkg::port_byte_t  port0_i,
	input  wire mcr_input_pkg::port_byte_t  port1_i,
	input  wire mcr_input_pkg::port_byte_t  port2_i,
	input  wire mcr_input_pkg::port_byte_t  port3_i,
	input  wire mcr_input_pkg::port_byte_t  port4_i,
	output int                              error_count_o,
	output int                              check_count_o
);
	import mcr_input_pkg::*;

	int errors = 0;
	int checks = 0;

	assign error_count_o = errors;
	assign check_count_o = checks;

	task automatic compare_port(input int idx, input port_byte_t exp_v, input port_byte_t act_v);
		if (exp_v !== act_v) begin
			$display("error %0s port%0d expected %h actual %h", test_name_i, idx, exp_v, act_v);
			errors++;
		end
	endtask

	// sample mid cycle, ports settled
	always @(negedge clk_sys) begin
		if (check_i) begin
			checks++;
			compare_port(0, exp0_i, port0_i);
			compare_port(1, exp1_i, port1_i);
			compare_port(2, exp2_i, port2_i);
			compare_port(3, exp3_i, port3_i);
			compare_port(4, exp4_i, port4_i);
		end
	end

endmodule

`default_nettype wire

//--- dv/spinner_checker.sv
// spinner checker
// concurrent assertions on the angle counter of every spinner instance
`timescale 1ns/100ps
`default_nettype none

module spinner_checker (
	input wire                              clk_sys,
	input wire                              hard_reset,
	input wire                              spin_fast_i,
	input wire                              btn_left_i,
	input wire                              btn_right_i,
	input wire                              vsync_i,
	input wire mcr_input_pkg::spin_angle_t  spin_angle_i
);
	import mcr_input_pkg::*;

	int fail_count = 0;

	// angle cleared by reset
	assert property (@(posedge clk_sys) hard_reset |=> spin_angle_i == '0)
		else begin
			fail_count++;
			$error("spinner angle not zero after reset");
		end

	// rise is vsync high after a low sample or straight out of reset
	// angle holds in every cycle without one
	assert property (@(posedge clk_sys) disable iff (hard_reset)
		!(vsync_i && ($past(hard_reset) || !$past(vsync_i))) |=>
		spin_angle_i == $past(spin_angle_i))
		else begin
			fail_count++;
			$error("spinner angle moved without a vsync rise");
		end

	// right alone steps the angle up
	assert property (@(posedge clk_sys) disable iff (hard_reset)
		vsync_i && ($past(hard_reset) || !$past(vsync_i)) &&
		btn_right_i && !btn_left_i |=>
		spin_angle_i == spin_angle_t'($past(spin_angle_i) +
			($past(spin_fast_i) ? SPIN_STEP_FAST : SPIN_STEP_SLOW)))
		else begin
			fail_count++;
			$error("spinner angle did not step up on right");
		end

endmodule

bind spinner spinner_checker u_spinner_checker (
	.clk_sys      (clk_sys),
	.hard_reset   (hard_reset),
	.spin_fast_i  (spin_fast_i),
	.btn_left_i   (btn_left_i),
	.btn_right_i  (btn_right_i),
	.vsync_i      (vsync_i),
	.spin_angle_i (spin_angle_o)
);

`default_nettype wire

//--- design/mcr_input_top.sv
// mcr input top
// control-input section of the multi-game board: mouse tracker,
// two spinners and the CPU input port mux
`timescale 1ns/100ps
`default_nettype none

module mcr_input_top (
	input  wire                              clk_sys,
	input  wire                              hard_reset,
	input  wire mcr_input_pkg::game_t        game_sel_i,
	input  wire mcr_input_pkg::dir_t         p1_dir_i,
	input  wire mcr_input_pkg::dir_t         p2_dir_i,
	input  wire mcr_input_pkg::fire_t        p1_fire_i,
	input  wire mcr_input_pkg::fire_t        p2_fire_i,
	input  wire [1:0]                        coin_i,
	input  wire [2:0]                        start_i,
	input  wire                              tilt_i,
	input  wire                              service_i,
	input  wire [1:0]                        option_i,
	input  wire                              rotate_i,
	input  wire                              spin_fast_i,
	input  wire                              vsync_i,
	input  wire mcr_input_pkg::mouse_delta_t mouse_dx_i,
	input  wire mcr_input_pkg::mouse_delta_t mouse_dy_i,
	input  wire [1:0]                        mouse_btn_i,
	input  wire                              mouse_strobe_i,
	output wire mcr_input_pkg::port_byte_t   port0_o,
	output wire mcr_input_pkg::port_byte_t   port1_o,
	output wire mcr_input_pkg::port_byte_t   port2_o,
	output wire mcr_input_pkg::port_byte_t   port3_o,
	output wire mcr_input_pkg::port_byte_t   port4_o
);
	import mcr_input_pkg::*;

	wacko_pos_t  wacko_x;
	wacko_pos_t  wacko_y;
	kroozr_pos_t kroozr_x;
	kroozr_pos_t kroozr_y;
	logic [1:0]  mouse_btns;
	spin_angle_t spin1;
	spin_angle_t spin2;

	// ====================
	// mouse
	// ====================
	mouse_tracker u_mouse_tracker (
		.clk_sys        (clk_sys),
		.hard_reset     (hard_reset),
		.rotate_i       (rotate_i),
		.mouse_strobe_i (mouse_strobe_i),
		.mouse_dx_i     (mouse_dx_i),
		.mouse_dy_i     (mouse_dy_i),
		.mouse_btn_i    (mouse_btn_i),
		.wacko_x_o      (wacko_x),
		.wacko_y_o      (wacko_y),
		.kroozr_x_o     (kroozr_x),
		.kroozr_y_o     (kroozr_y),
		.mouse_btns_o   (mouse_btns)
	);

	// ====================
	// spinners
	// ====================
	// left or up turns left, right or down turns right
	spinner u_spin1 (
		.clk_sys      (clk_sys),
		.hard_reset   (hard_reset),
		.spin_fast_i  (spin_fast_i),
		.btn_left_i   (p1_dir_i[1] | p1_dir_i[3]),
		.btn_right_i  (p1_dir_i[0] | p1_dir_i[2]),
		.vsync_i      (vsync_i),
		.spin_angle_o (spin1)
	);

	spinner u_spin2 (
		.clk_sys      (clk_sys),
		.hard_reset   (hard_reset),
		.spin_fast_i  (spin_fast_i),
		.btn_left_i   (p2_dir_i[1] | p2_dir_i[3]),
		.btn_right_i  (p2_dir_i[0] | p2_dir_i[2]),
		.vsync_i      (vsync_i),
		.spin_angle_o (spin2)
	);

	// ====================
	// CPU ports
	// ====================
	input_port_mux u_port_mux (
		.clk_sys      (clk_sys),
		.hard_reset   (hard_reset),
		.game_sel_i   (game_sel_i),
		.p1_dir_i     (p1_dir_i),
		.p2_dir_i     (p2_dir_i),
		.p1_fire_i    (p1_fire_i),
		.p2_fire_i    (p2_fire_i),
		.coin_i       (coin_i),
		.start_i      (start_i),
		.tilt_i       (tilt_i),
		.service_i    (service_i),
		.option_i     (option_i),
		.wacko_x_i    (wacko_x),
		.wacko_y_i    (wacko_y),
		.kroozr_x_i   (kroozr_x),
		.kroozr_y_i   (kroozr_y),
		.mouse_btns_i (mouse_btns),
		.spin1_i      (spin1),
		.spin2_i      (spin2),
		.port0_o      (port0_o),
		.port1_o      (port1_o),
		.port2_o      (port2_o),
		.port3_o      (port3_o),
		.port4_o      (port4_o)
	);

endmodule

`default_nettype wire

//--- design/input_port_mux.sv
// input port mux
// builds the five active-low CPU input ports for the selected
// game from buttons, mouse positions and spinner angles, and
// registers them toward the CPU
`timescale 1ns/100ps
`default_nettype none

module input_port_mux (
	input  wire                              clk_sys,
	input  wire                              hard_reset,
	input  wire mcr_input_pkg::game_t        game_sel_i,
	input  wire mcr_input_pkg::dir_t         p1_dir_i,
	input  wire mcr_input_pkg::dir_t         p2_dir_i,
	input  wire mcr_input_pkg::fire_t        p1_fire_i,
	input  wire mcr_input_pkg::fire_t        p2_fire_i,
	input  wire [1:0]                        coin_i,
	input  wire [2:0]                        start_i,
	input  wire                              tilt_i,
	input  wire                              service_i,
	input  wire [1:0]                        option_i,
	input  wire mcr_input_pkg::wacko_pos_t   wacko_x_i,
	input  wire mcr_input_pkg::wacko_pos_t   wacko_y_i,
	input  wire mcr_input_pkg::kroozr_pos_t  kroozr_x_i,
	input  wire mcr_input_pkg::kroozr_pos_t  kroozr_y_i,
	input  wire [1:0]                        mouse_btns_i,
	input  wire mcr_input_pkg::spin_angle_t  spin1_i,
	input  wire mcr_input_pkg::spin_angle_t  spin2_i,
	output mcr_input_pkg::port_byte_t        port0_o,
	output mcr_input_pkg::port_byte_t        port1_o,
	output mcr_input_pkg::port_byte_t        port2_o,
	output mcr_input_pkg::port_byte_t        port3_o,
	output mcr_input_pkg::port_byte_t        port4_o
);
	import mcr_input_pkg::*;

	port_byte_t port0_d;
	port_byte_t port1_d;
	port_byte_t port2_d;
	port_byte_t port3_d;
	port_byte_t port4_d;
	logic       port0_x;
	// down, up, right, left as several games want it
	logic [3:0] p1_durl;
	logic [3:0] p2_durl;

	assign p1_durl = {p1_dir_i[2], p1_dir_i[3], p1_dir_i[0], p1_dir_i[1]};
	assign p2_durl = {p2_dir_i[2], p2_dir_i[3], p2_dir_i[0], p2_dir_i[1]};

	// ====================
	// port0 spare bit
	// ====================
	always_comb begin
		case (game_sel_i)
			TRON, DOMINO: port0_x = p1_fire_i[0];
			TWOTIGER:     port0_x = start_i[2];
			KROOZR:       port0_x = p1_fire_i[0] | mouse_btns_i[0];
			default:      port0_x = 1'b0;
		endcase
	end

	// ====================
	// per-game mapping
	// ====================
	always_comb begin
		// coins, starts, tilt and service common to every game
		port0_d = ~{service_i, 1'b0, tilt_i, port0_x, start_i[1:0], coin_i};
		port1_d = PORT_IDLE;
		port2_d = PORT_IDLE;
		port3_d = PORT_IDLE;
		port4_d = PORT_IDLE;
		case (game_sel_i)
			SHOLLOW: begin
				port1_d = ~{p2_fire_i[0], p2_fire_i[1], p2_dir_i[0], p2_dir_i[1],
					p1_fire_i[0], p1_fire_i[1], p1_dir_i[0], p1_dir_i[1]};
				port3_d = ~8'h02;
			end
			TRON: begin
				// second spinner shows on both ports
				port1_d = ~{1'b0, spin2_i};
				port2_d = ~{p1_durl, p1_durl};
				// option0 allows continue
				port3_d = ~{p1_fire_i[0], 4'b0000, option_i[0], 2'b10};
				port4_d = ~{1'b0, spin2_i};
			end
			TWOTIGER: begin
				port1_d = ~{1'b0, spin1_i};
				port2_d = ~{4'b0000, p2_fire_i[1], p2_fire_i[0], p1_fire_i[1], p1_fire_i[0]};
				port4_d = ~{1'b0, spin2_i};
			end
			WACKO: begin
				// trackball, upper bits only, not inverted
				port1_d = wacko_x_i[10:3];
				port2_d = wacko_y_i[10:3];
				port3_d = ~8'h40;
				port4_d = ~{p2_dir_i, p1_dir_i};
			end
			KROOZR: begin
				port1_d = ~{p1_fire_i[1] | mouse_btns_i[1], spin1_i[6], 3'b111, spin1_i[5:3]};
				// sign doubled over the middle bits
				port2_d = {kroozr_x_i[9], kroozr_x_i[9], kroozr_x_i[7:2]};
				port3_d = ~8'h40;
				port4_d = {kroozr_y_i[9], kroozr_y_i[9], kroozr_y_i[7:2]};
			end
			DOMINO: begin
				port1_d = ~{4'b0000, p1_durl};
				port2_d = ~{3'b000, p2_fire_i[0], p2_durl};
				// option1 skin, option0 music
				port3_d = ~{6'b010000, option_i[1], option_i[0]};
			end
			default: ;
		endcase
	end

	// ====================
	// output registers
	// ====================
	always_ff @(posedge clk_sys) begin
		if (hard_reset) begin
			port0_o <= PORT_IDLE;
			port1_o <= PORT_IDLE;
			port2_o <= PORT_IDLE;
			port3_o <= PORT_IDLE;
			port4_o <= PORT_IDLE;
		end else begin
			port0_o <= port0_d;
			port1_o <= port1_d;
			port2_o <= port2_d;
			port3_o <= port3_d;
			port4_o <= port4_d;
		end
	end

endmodule

`default_nettype wire

//--- design/spinner.sv
// spinner
// 7-bit angle counter for the rotary controls, stepped once per
// rising edge of vertical sync while a direction is held
`timescale 1ns/100ps
`default_nettype none

module spinner (
	input  wire                  clk_sys,
	input  wire                  hard_reset,
	input  wire                  spin_fast_i,
	input  wire                  btn_left_i,
	input  wire                  btn_right_i,
	input  wire                  vsync_i,
	output mcr_input_pkg::spin_angle_t spin_angle_o
);
	import mcr_input_pkg::*;

	logic        vsync_q;
	logic        vsync_rise;
	spin_angle_t step;

	// ====================
	// vsync edge detect
	// ====================
	always_ff @(posedge clk_sys) begin
		if (hard_reset)
			vsync_q <= 1'b0;
		else
			vsync_q <= vsync_i;
	end

	// high now, low last cycle
	assign vsync_rise = vsync_i & ~vsync_q;

	// speed option
	assign step = spin_fast_i ? SPIN_STEP_FAST : SPIN_STEP_SLOW;

	// ====================
	// angle counter
	// ====================
	always_ff @(posedge clk_sys) begin
		if (hard_reset) begin
			spin_angle_o <= '0;
		end else if (vsync_rise) begin
			// both or neither held, stay put
			if (btn_left_i && !btn_right_i)
				spin_angle_o <= spin_angle_o - step;
			else if (btn_right_i && !btn_left_i)
				spin_angle_o <= spin_angle_o + step;
		end
	end

endmodule

`default_nettype wire

//--- design/mouse_tracker.sv
// mouse tracker
// integrates decoded mouse deltas into the wacko position (free
// wrap) and the kozmik krooz'r position (refuses overflow), and
// latches the mouse buttons on every strobe
`timescale 1ns/100ps
`default_nettype none

module mouse_tracker (
	input  wire                              clk_sys,
	input  wire                              hard_reset,
	input  wire                              rotate_i,
	input  wire                              mouse_strobe_i,
	input  wire mcr_input_pkg::mouse_delta_t mouse_dx_i,
	input  wire mcr_input_pkg::mouse_delta_t mouse_dy_i,
	input  wire [1:0]                        mouse_btn_i,
	output mcr_input_pkg::wacko_pos_t        wacko_x_o,
	output mcr_input_pkg::wacko_pos_t        wacko_y_o,
	output mcr_input_pkg::kroozr_pos_t       kroozr_x_o,
	output mcr_input_pkg::kroozr_pos_t       kroozr_y_o,
	output logic [1:0]                       mouse_btns_o
);
	import mcr_input_pkg::*;

	// ====================
	// krooz'r move terms
	// ====================
	mouse_delta_t move_x;
	mouse_delta_t move_y;
	kroozr_pos_t  kx_next;
	kroozr_pos_t  ky_next;
	logic         kx_ovf;
	logic         ky_ovf;

	// rotated cabinet swaps the axes
	assign move_x = rotate_i ? -mouse_dy_i : mouse_dx_i;
	assign move_y = rotate_i ? mouse_dx_i : mouse_dy_i;

	// x is subtracted, y added
	assign kx_next = kroozr_x_o - kroozr_pos_t'(move_x);
	assign ky_next = kroozr_y_o + kroozr_pos_t'(move_y);

	// sub overflow: operand signs differ and result flips sign
	assign kx_ovf = (move_x[DELTA_W-1] != kroozr_x_o[KROOZR_W-1]) &&
		(kx_next[KROOZR_W-1] != kroozr_x_o[KROOZR_W-1]);
	// add overflow: operand signs match and result flips sign
	assign ky_ovf = (move_y[DELTA_W-1] == kroozr_y_o[KROOZR_W-1]) &&
		(ky_next[KROOZR_W-1] != kroozr_y_o[KROOZR_W-1]);

	// ====================
	// position registers
	// ====================
	always_ff @(posedge clk_sys) begin
		if (hard_reset) begin
			wacko_x_o    <= '0;
			wacko_y_o    <= '0;
			kroozr_x_o   <= '0;
			kroozr_y_o   <= '0;
			mouse_btns_o <= 2'b00;
		end else if (mouse_strobe_i) begin
			// wacko, wraps at 11 bits
			if (rotate_i) begin
				wacko_x_o <= wacko_x_o - wacko_pos_t'(mouse_dy_i);
				wacko_y_o <= wacko_y_o + wacko_pos_t'(mouse_dx_i);
			end else begin
				wacko_x_o <= wacko_x_o + wacko_pos_t'(mouse_dx_i);
				wacko_y_o <= wacko_y_o + wacko_pos_t'(mouse_dy_i);
			end
			// krooz'r, hold axis on overflow
			if (!kx_ovf)
				kroozr_x_o <= kx_next;
			if (!ky_ovf)
				kroozr_y_o <= ky_next;
			// left in bit 0, right in bit 1
			mouse_btns_o <= mouse_btn_i;
		end
	end

endmodule

`default_nettype wire

//--- design/mcr_input_pkg.sv
// mcr input package
// shared widths, vector types, game select enum and spinner
// step constants for the arcade control-input section
`default_nettype none

package mcr_input_pkg;

	// ====================
	// widths
	// ====================
	localparam int PORT_W   = 8;
	localparam int DELTA_W  = 9;
	localparam int WACKO_W  = 11;
	localparam int KROOZR_W = 10;
	localparam int ANGLE_W  = 7;

	// ====================
	// vector types
	// ====================
	// one byte as seen by the game CPU
	typedef logic [PORT_W-1:0] port_byte_t;
	// decoded mouse motion, two's complement
	typedef logic signed [DELTA_W-1:0] mouse_delta_t;
	// wacko trackball position, wraps freely
	typedef logic signed [WACKO_W-1:0] wacko_pos_t;
	// krooz'r position, saturating
	typedef logic signed [KROOZR_W-1:0] kroozr_pos_t;
	// spinner angle, modulo 128
	typedef logic [ANGLE_W-1:0] spin_angle_t;
	// joystick, bit 3 up, 2 down, 1 left, 0 right
	typedef logic [3:0] dir_t;
	// fire buttons, bit 2 C, 1 B, 0 A
	typedef logic [2:0] fire_t;

	// game select, order matches the board's core index
	typedef enum logic [2:0] {
		SHOLLOW,
		TRON,
		TWOTIGER,
		WACKO,
		KROOZR,
		DOMINO
	} game_t;

	// ====================
	// constants
	// ====================
	// angle step per vsync
	localparam spin_angle_t SPIN_STEP_SLOW = 7'd1;
	localparam spin_angle_t SPIN_STEP_FAST = 7'd3;
	// all inputs released, ports are active low
	localparam port_byte_t PORT_IDLE = 8'hFF;

endpackage

`default_nettype wire
